// ==== logic/trap_pkg.sv ====
// machine mode only, one hart, RV32; mtvec modes 2 and 3 behave as direct mode
`default_nettype none

package trap_pkg;

	typedef logic [31:0] word_t;
	typedef logic [11:0] csr_addr_t;

	localparam csr_addr_t CSR_MSTATUS  = 12'h300;
	localparam csr_addr_t CSR_MIE      = 12'h304;
	localparam csr_addr_t CSR_MTVEC    = 12'h305;
	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MEPC     = 12'h341;
	localparam csr_addr_t CSR_MCAUSE   = 12'h342;
	localparam csr_addr_t CSR_MTVAL    = 12'h343;
	localparam csr_addr_t CSR_MIP      = 12'h344;
	localparam csr_addr_t CSR_MHARTID  = 12'hf14;
	localparam csr_addr_t CSR_MTIME    = 12'hc01;	// time shadow, read only
	localparam csr_addr_t CSR_MTIMEH   = 12'hc81;

	// bit index of each csr in the one-hot select
	localparam int SEL_MSTATUS  = 0;
	localparam int SEL_MIE      = 1;
	localparam int SEL_MTVEC    = 2;
	localparam int SEL_MSCRATCH = 3;
	localparam int SEL_MEPC     = 4;
	localparam int SEL_MCAUSE   = 5;
	localparam int SEL_MTVAL    = 6;
	localparam int SEL_MIP      = 7;
	localparam int SEL_MHARTID  = 8;
	localparam int SEL_MTIME    = 9;
	localparam int SEL_MTIMEH   = 10;
	localparam int NUM_CSR      = 11;

	typedef enum logic [1:0] {
		CSR_READ  = 2'd0,
		CSR_WRITE = 2'd1,
		CSR_SET   = 2'd2,
		CSR_CLEAR = 2'd3
	} csr_op_e;

	localparam logic [3:0] CAUSE_PC_MISALIGNED = 4'd0;
	localparam logic [3:0] CAUSE_ILLEGAL       = 4'd2;
	localparam logic [3:0] CAUSE_ECALL_M       = 4'd11;
	localparam logic [3:0] CAUSE_TIMER_INT     = 4'd7;
	localparam logic [3:0] CAUSE_EXT_INT       = 4'd11;

	localparam int MSTATUS_MIE  = 3;
	localparam int MSTATUS_MPIE = 7;
	localparam int MIE_MEIE     = 11;	// also mip.MEIP
	localparam int MIE_MTIE     = 7;	// also mip.MTIP

	localparam logic [1:0] MTVEC_VECTORED = 2'd1;

	typedef union packed {
		word_t raw;
		struct packed {
			logic [29:0] base;
			logic [1:0]  mode;
		} f;
	} mtvec_u;

	typedef union packed {
		word_t raw;
		struct packed {
			logic        irq;
			logic [26:0] zero;
			logic [3:0]  code;
		} f;
	} mcause_u;

endpackage

`default_nettype wire

// ==== logic/csr_decode.sv ====
// purely combinational; set or clear with zero data counts as a read, so it may hit read-only CSRs
`default_nettype none

module csr_decode import trap_pkg::*; (
	input  wire logic                   csr_access,	// one-cycle command strobe
	input  wire csr_op_e                csr_op,
	input  wire csr_addr_t              csr_addr,
	input  wire word_t                  csr_wdata,
	output logic      [NUM_CSR - 1 : 0] csr_sel,	// one-hot, zero when idle
	output logic                        csr_we,
	output logic                        csr_illegal
);

	logic [NUM_CSR - 1 : 0] hit;
	logic                   known;
	logic                   wr_intent;
	logic                   read_only;

	// address match
	always_comb begin
		hit = '0;
		case (csr_addr)
			CSR_MSTATUS:  hit[SEL_MSTATUS]  = 1'b1;
			CSR_MIE:      hit[SEL_MIE]      = 1'b1;
			CSR_MTVEC:    hit[SEL_MTVEC]    = 1'b1;
			CSR_MSCRATCH: hit[SEL_MSCRATCH] = 1'b1;
			CSR_MEPC:     hit[SEL_MEPC]     = 1'b1;
			CSR_MCAUSE:   hit[SEL_MCAUSE]   = 1'b1;
			CSR_MTVAL:    hit[SEL_MTVAL]    = 1'b1;
			CSR_MIP:      hit[SEL_MIP]      = 1'b1;
			CSR_MHARTID:  hit[SEL_MHARTID]  = 1'b1;
			CSR_MTIME:    hit[SEL_MTIME]    = 1'b1;
			CSR_MTIMEH:   hit[SEL_MTIMEH]   = 1'b1;
			default:      hit = '0;
		endcase
	end

	assign known = |hit;

	// csrrs / csrrc with zero data only read
	always_comb begin
		case (csr_op)
			CSR_WRITE:           wr_intent = 1'b1;
			CSR_SET, CSR_CLEAR:  wr_intent = |csr_wdata;
			CSR_READ:            wr_intent = 1'b0;
			default:             wr_intent = 1'b0;
		endcase
	end

	assign read_only = hit[SEL_MHARTID] | hit[SEL_MTIME] | hit[SEL_MTIMEH];

	assign csr_sel     = csr_access ? hit : '0;
	assign csr_illegal = csr_access & (~known | (wr_intent & read_only));
	assign csr_we      = csr_access & wr_intent & known & ~read_only;	// no write on illegal

endmodule

`default_nettype wire

// ==== logic/mcsr.sv ====
// mstatus keeps MIE and MPIE only; mip follows the interrupt levels and ignores writes
`default_nettype none

module mcsr import trap_pkg::*; #(
	parameter word_t MTVEC_RESET = 32'h0000_0100,
	parameter word_t HART_ID     = 32'h0000_0000
) (
	input  wire logic                   cpu_clk,
	input  wire logic                   reset,
	input  wire logic                   csr_access,
	input  wire csr_op_e                csr_op,
	input  wire logic [NUM_CSR - 1 : 0] csr_sel,
	input  wire logic                   csr_we,
	input  wire word_t                  csr_wdata,
	input  wire logic [63:0]            mtime,
	input  wire logic                   ext_int,	// level
	input  wire logic                   timer_int,	// level
	input  wire logic                   trap_take,
	input  wire word_t                  mepc_next,
	input  wire mcause_u                mcause_next,
	input  wire word_t                  mtval_next,
	input  wire logic                   mret,
	output word_t                       csr_rdata,
	output logic                        csr_rvalid,
	output logic                        mstatus_mie,
	output logic [1:0]                  mie_bits,	// [1] external, [0] timer
	output logic [1:0]                  mip_bits,
	output mtvec_u                      mtvec,
	output word_t                       mepc
);

	logic  mstatus_mpie;
	word_t mscratch;
	word_t mcause_q;
	word_t mtval_q;
	word_t csr_vals [NUM_CSR];
	word_t rd_mux;
	word_t wr_val;

	function automatic word_t csr_modify(word_t old_val, csr_op_e op, word_t data);
		case (op)
			CSR_SET:   return old_val | data;
			CSR_CLEAR: return old_val & ~data;
			default:   return data;
		endcase
	endfunction

	// current value of every csr, laid out as software sees it
	always_comb begin
		csr_vals[SEL_MSTATUS]               = '0;
		csr_vals[SEL_MSTATUS][MSTATUS_MIE]  = mstatus_mie;
		csr_vals[SEL_MSTATUS][MSTATUS_MPIE] = mstatus_mpie;
		csr_vals[SEL_MIE]                   = '0;
		csr_vals[SEL_MIE][MIE_MEIE]         = mie_bits[1];
		csr_vals[SEL_MIE][MIE_MTIE]         = mie_bits[0];
		csr_vals[SEL_MIP]                   = '0;
		csr_vals[SEL_MIP][MIE_MEIE]         = mip_bits[1];
		csr_vals[SEL_MIP][MIE_MTIE]         = mip_bits[0];
		csr_vals[SEL_MTVEC]                 = mtvec.raw;
		csr_vals[SEL_MSCRATCH]              = mscratch;
		csr_vals[SEL_MEPC]                  = mepc;
		csr_vals[SEL_MCAUSE]                = mcause_q;
		csr_vals[SEL_MTVAL]                 = mtval_q;
		csr_vals[SEL_MHARTID]               = HART_ID;
		csr_vals[SEL_MTIME]                 = mtime[31:0];
		csr_vals[SEL_MTIMEH]                = mtime[63:32];
	end

	// one-hot and-or mux
	always_comb begin
		rd_mux = '0;
		for (int i = 0; i < NUM_CSR; i++) begin
			if (csr_sel[i])
				rd_mux = rd_mux | csr_vals[i];
		end
	end

	assign wr_val = csr_modify(rd_mux, csr_op, csr_wdata);

	// control state
	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_bits     <= 2'b00;
			mip_bits     <= 2'b00;
			mtvec.raw    <= MTVEC_RESET;
			csr_rvalid   <= 1'b0;
		end else begin
			mip_bits   <= {ext_int, timer_int};	// sampled every cycle
			csr_rvalid <= csr_access;
			if (trap_take) begin
				mstatus_mpie <= mstatus_mie;
				mstatus_mie  <= 1'b0;
			end else if (mret) begin
				mstatus_mie  <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
			end else if (csr_we && csr_sel[SEL_MSTATUS]) begin
				mstatus_mie  <= wr_val[MSTATUS_MIE];
				mstatus_mpie <= wr_val[MSTATUS_MPIE];
			end
			if (csr_we && csr_sel[SEL_MIE])
				mie_bits <= {wr_val[MIE_MEIE], wr_val[MIE_MTIE]};
			if (csr_we && csr_sel[SEL_MTVEC])
				mtvec.raw <= wr_val;
		end
	end

	// payload registers
	always_ff @(posedge cpu_clk) begin
		if (csr_access)
			csr_rdata <= rd_mux;	// value before this write
		if (csr_we && csr_sel[SEL_MSCRATCH])
			mscratch <= wr_val;
		if (trap_take) begin
			mepc     <= mepc_next;
			mcause_q <= mcause_next.raw;
			mtval_q  <= mtval_next;
		end else if (csr_we) begin
			if (csr_sel[SEL_MEPC])
				mepc <= wr_val;
			if (csr_sel[SEL_MCAUSE])
				mcause_q <= wr_val;
			if (csr_sel[SEL_MTVAL])
				mtval_q <= wr_val;
		end
	end

endmodule

`default_nettype wire

// ==== logic/trap_ctrl.sv ====
// no trap masking besides mstatus.MIE; an event and mret in the same cycle is not supported
`default_nettype none

module trap_ctrl import trap_pkg::*; (
	input  wire logic       cpu_clk,
	input  wire logic       reset,
	input  wire word_t      pc,		// saved to mepc
	input  wire word_t      fault_pc,
	input  wire word_t      instr,
	input  wire logic       pc_misaligned,
	input  wire logic       instr_illegal,
	input  wire logic       csr_illegal,
	input  wire logic       ecall,
	input  wire logic       mstatus_mie,
	input  wire logic [1:0] mie_bits,
	input  wire logic [1:0] mip_bits,
	input  wire mtvec_u     mtvec,
	output logic            trap_take,	// combinational, same cycle as the event
	output word_t           mepc_next,
	output mcause_u         mcause_next,
	output word_t           mtval_next,
	output logic            trap,
	output word_t           trap_vector,
	output logic            csr_illegal_access
);

	logic  exc_any;
	logic  ext_pend;
	logic  tmr_pend;
	word_t base_addr;
	word_t vector_addr;

	assign exc_any  = pc_misaligned | instr_illegal | csr_illegal | ecall;
	assign ext_pend = mstatus_mie & mie_bits[1] & mip_bits[1];
	assign tmr_pend = mstatus_mie & mie_bits[0] & mip_bits[0];

	assign trap_take = exc_any | ext_pend | tmr_pend;
	assign mepc_next = pc;

	// priority: misaligned, illegal, ecall, then external, then timer
	always_comb begin
		mcause_next.f.irq  = 1'b0;
		mcause_next.f.zero = '0;
		mcause_next.f.code = '0;
		mtval_next         = '0;
		if (pc_misaligned) begin
			mcause_next.f.code = CAUSE_PC_MISALIGNED;
			mtval_next         = fault_pc;
		end else if (instr_illegal || csr_illegal) begin
			mcause_next.f.code = CAUSE_ILLEGAL;
			mtval_next         = instr;
		end else if (ecall) begin
			mcause_next.f.code = CAUSE_ECALL_M;
		end else if (ext_pend) begin
			mcause_next.f.irq  = 1'b1;
			mcause_next.f.code = CAUSE_EXT_INT;
		end else if (tmr_pend) begin
			mcause_next.f.irq  = 1'b1;
			mcause_next.f.code = CAUSE_TIMER_INT;
		end
	end

	assign base_addr = {mtvec.f.base, 2'b00};

	// vectored mode only offsets interrupts
	always_comb begin
		if (mtvec.f.mode == MTVEC_VECTORED && mcause_next.f.irq)
			vector_addr = base_addr + {26'd0, mcause_next.f.code, 2'b00};
		else
			vector_addr = base_addr;
	end

	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			trap               <= 1'b0;
			csr_illegal_access <= 1'b0;
		end else begin
			trap               <= trap_take;	// one-cycle pulse
			csr_illegal_access <= csr_illegal;
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (trap_take)
			trap_vector <= vector_addr;
	end

endmodule

`default_nettype wire

// ==== logic/machine_trap_unit.sv ====
// strobes are single-cycle and never stalled; interrupts trap two cycles after the level rises
`default_nettype none

module machine_trap_unit import trap_pkg::*; #(
	parameter word_t MTVEC_RESET = 32'h0000_0100,
	parameter word_t HART_ID     = 32'h0000_0000
) (
	input  wire logic        cpu_clk,
	input  wire logic        reset,		// synchronous
	input  wire logic        csr_access,
	input  wire csr_op_e     csr_op,
	input  wire csr_addr_t   csr_addr,
	input  wire word_t       csr_wdata,
	input  wire word_t       instr,		// csr or faulting instruction word
	input  wire word_t       pc,
	input  wire word_t       fault_pc,
	input  wire logic        pc_misaligned,
	input  wire logic        instr_illegal,
	input  wire logic        ecall,
	input  wire logic        mret,
	input  wire logic        ext_int,
	input  wire logic        timer_int,
	input  wire logic [63:0] mtime,
	output word_t            csr_rdata,
	output logic             csr_rvalid,
	output logic             csr_illegal_access,
	output logic             trap,
	output word_t            trap_vector,
	output word_t            mret_pc	// live mepc
);

	logic [NUM_CSR - 1 : 0] csr_sel;
	logic                   csr_we;
	logic                   csr_illegal;
	logic                   trap_take;
	word_t                  mepc_next;
	mcause_u                mcause_next;
	word_t                  mtval_next;
	logic                   mstatus_mie;
	logic [1:0]             mie_bits;
	logic [1:0]             mip_bits;
	mtvec_u                 mtvec;

	csr_decode u_csr_decode (
		.csr_access  (csr_access),
		.csr_op      (csr_op),
		.csr_addr    (csr_addr),
		.csr_wdata   (csr_wdata),
		.csr_sel     (csr_sel),
		.csr_we      (csr_we),
		.csr_illegal (csr_illegal)
	);

	mcsr #(
		.MTVEC_RESET (MTVEC_RESET),
		.HART_ID     (HART_ID)
	) u_mcsr (
		.cpu_clk     (cpu_clk),
		.reset       (reset),
		.csr_access  (csr_access),
		.csr_op      (csr_op),
		.csr_sel     (csr_sel),
		.csr_we      (csr_we),
		.csr_wdata   (csr_wdata),
		.mtime       (mtime),
		.ext_int     (ext_int),
		.timer_int   (timer_int),
		.trap_take   (trap_take),
		.mepc_next   (mepc_next),
		.mcause_next (mcause_next),
		.mtval_next  (mtval_next),
		.mret        (mret),
		.csr_rdata   (csr_rdata),
		.csr_rvalid  (csr_rvalid),
		.mstatus_mie (mstatus_mie),
		.mie_bits    (mie_bits),
		.mip_bits    (mip_bits),
		.mtvec       (mtvec),
		.mepc        (mret_pc)
	);

	trap_ctrl u_trap_ctrl (
		.cpu_clk            (cpu_clk),
		.reset              (reset),
		.pc                 (pc),
		.fault_pc           (fault_pc),
		.instr              (instr),
		.pc_misaligned      (pc_misaligned),
		.instr_illegal      (instr_illegal),
		.csr_illegal        (csr_illegal),
		.ecall              (ecall),
		.mstatus_mie        (mstatus_mie),
		.mie_bits           (mie_bits),
		.mip_bits           (mip_bits),
		.mtvec              (mtvec),
		.trap_take          (trap_take),
		.mepc_next          (mepc_next),
		.mcause_next        (mcause_next),
		.mtval_next         (mtval_next),
		.trap               (trap),
		.trap_vector        (trap_vector),
		.csr_illegal_access (csr_illegal_access)
	);

endmodule

`default_nettype wire

// ==== verif/tb_util.svh ====
// included inside the testbench module; relies on its clock, DUT inputs and model variables
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// advances the shared generator state
function automatic logic [31:0] next_rand();
	rng_state = xorshift(rng_state);
	return rng_state;
endfunction

// one csr command; the read result is checked by an assertion one cycle later
task automatic csr_cmd(input csr_op_e op, input csr_addr_t addr, input word_t data,
		input word_t exp_old, input logic ill);
	@(posedge cpu_clk);
	last_pc    = next_rand() & 32'hffff_fffc;
	last_instr = next_rand();
	csr_access <= 1'b1;
	csr_op     <= op;
	csr_addr   <= addr;
	csr_wdata  <= data;
	instr      <= last_instr;
	pc         <= last_pc;
	exp_rdata  <= exp_old;
	trig_exc   <= ill;	// illegal access traps one cycle later
	trig_ill   <= ill;
	@(posedge cpu_clk);
	csr_access <= 1'b0;
	trig_exc   <= 1'b0;
	trig_ill   <= 1'b0;
	@(negedge cpu_clk);
	while (!csr_rvalid)
		@(negedge cpu_clk);
endtask

task automatic test_done(input string name);
	tests_run++;
	$display("test %0d (%s) finished, errors so far %0d", tests_run, name, errors);
endtask

`endif

// ==== verif/machine_trap_unit_tb.sv ====
// drives the trap unit through reset, csr access, exceptions and interrupts; stops at 600 cycles
`default_nettype none

module machine_trap_unit_tb import trap_pkg::*;;

	localparam word_t TB_MTVEC   = 32'h0000_0400;
	localparam word_t TB_HART    = 32'h0000_0003;
	localparam int    MAX_CYCLES = 600;
	localparam word_t MIE_MASK   = 32'h0000_0880;	// meie and mtie

	logic        cpu_clk;
	logic        reset;
	logic        csr_access;
	csr_op_e     csr_op;
	csr_addr_t   csr_addr;
	word_t       csr_wdata;
	word_t       instr;
	word_t       pc;
	word_t       fault_pc;
	logic        pc_misaligned;
	logic        instr_illegal;
	logic        ecall;
	logic        mret;
	logic        ext_int;
	logic        timer_int;
	logic [63:0] mtime;
	word_t       csr_rdata;
	logic        csr_rvalid;
	logic        csr_illegal_access;
	logic        trap;
	word_t       trap_vector;
	word_t       mret_pc;

	// expectations seen by the assertions
	word_t exp_rdata;
	word_t exp_vec;
	word_t exp_mepc;
	logic  trig_exc;
	logic  trig_ill;
	logic  trig_int;
	logic  trig_int_d;
	logic  quiet;
	logic  rd_skip;	// old value undefined, read data not compared

	// reference model
	word_t mscratch_m;
	word_t mtvec_m;
	word_t mie_m;
	logic  mstat_mie;
	logic  mstat_mpie;
	word_t last_pc;
	word_t last_instr;
	logic [31:0] rng_state;
	int    errors;
	int    tests_run;
	int    cycles;

	`include "tb_util.svh"

	machine_trap_unit #(
		.MTVEC_RESET (TB_MTVEC),
		.HART_ID     (TB_HART)
	) dut0 (
		.cpu_clk            (cpu_clk),
		.reset              (reset),
		.csr_access         (csr_access),
		.csr_op             (csr_op),
		.csr_addr           (csr_addr),
		.csr_wdata          (csr_wdata),
		.instr              (instr),
		.pc                 (pc),
		.fault_pc           (fault_pc),
		.pc_misaligned      (pc_misaligned),
		.instr_illegal      (instr_illegal),
		.ecall              (ecall),
		.mret               (mret),
		.ext_int            (ext_int),
		.timer_int          (timer_int),
		.mtime              (mtime),
		.csr_rdata          (csr_rdata),
		.csr_rvalid         (csr_rvalid),
		.csr_illegal_access (csr_illegal_access),
		.trap               (trap),
		.trap_vector        (trap_vector),
		.mret_pc            (mret_pc)
	);

	initial begin
		cpu_clk = 1'b0;
		forever #50 cpu_clk = ~cpu_clk;
	end

	always @(posedge cpu_clk)
		trig_int_d <= trig_int;	// interrupts take one cycle more than exceptions

	a_rdata: assert property (@(posedge cpu_clk) disable iff (reset)
		(csr_access && !rd_skip) |=> (csr_rvalid && csr_rdata == exp_rdata))
	else begin
		errors++;
		$display("Fail %0t: csr_rdata %h, expected %h", $time, csr_rdata, exp_rdata);
	end

	a_exc: assert property (@(posedge cpu_clk) disable iff (reset)
		trig_exc |=> (trap && trap_vector == exp_vec))
	else begin
		errors++;
		$display("Fail %0t: exception trap %b vector %h, expected %h", $time, trap,
			trap_vector, exp_vec);
	end

	a_int: assert property (@(posedge cpu_clk) disable iff (reset)
		trig_int_d |=> (trap && trap_vector == exp_vec))
	else begin
		errors++;
		$display("Fail %0t: interrupt trap %b vector %h, expected %h", $time, trap,
			trap_vector, exp_vec);
	end

	a_ill: assert property (@(posedge cpu_clk) disable iff (reset)
		trig_ill |=> csr_illegal_access)
	else begin
		errors++;
		$display("Fail %0t: csr_illegal_access not raised", $time);
	end

	a_quiet: assert property (@(posedge cpu_clk) disable iff (reset) quiet |-> !trap)
	else begin
		errors++;
		$display("Fail %0t: unexpected trap", $time);
	end

	a_mret: assert property (@(posedge cpu_clk) disable iff (reset)
		mret |-> (mret_pc == exp_mepc))
	else begin
		errors++;
		$display("Fail %0t: mret_pc %h, expected %h", $time, mret_pc, exp_mepc);
	end

	// run limit
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge cpu_clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	task automatic raise_exc(input logic mis, input logic ecl);
		@(posedge cpu_clk);
		last_pc  = next_rand() & 32'hffff_fffc;
		pc            <= last_pc;
		fault_pc      <= last_pc | 32'h2;
		pc_misaligned <= mis;
		ecall         <= ecl;
		trig_exc      <= 1'b1;
		@(posedge cpu_clk);
		pc_misaligned <= 1'b0;
		ecall         <= 1'b0;
		trig_exc      <= 1'b0;
		@(negedge cpu_clk);
		while (!trap)
			@(negedge cpu_clk);
		exp_mepc   = last_pc;
		mstat_mpie = mstat_mie;
		mstat_mie  = 1'b0;
	endtask

	task automatic wait_trap();
		@(negedge cpu_clk);
		while (!trap)
			@(negedge cpu_clk);
	endtask

	initial begin
		word_t r;
		word_t vbase;
		word_t nv;
		csr_op_e op;
		reset = 1'b1;
		csr_access = 1'b0;
		csr_op = CSR_READ;
		csr_addr = '0;
		csr_wdata = '0;
		instr = '0;
		pc = '0;
		fault_pc = '0;
		pc_misaligned = 1'b0;
		instr_illegal = 1'b0;
		ecall = 1'b0;
		mret = 1'b0;
		ext_int = 1'b0;
		timer_int = 1'b0;
		mtime = '0;
		exp_rdata = '0;
		exp_vec = '0;
		exp_mepc = '0;
		trig_exc = 1'b0;
		trig_ill = 1'b0;
		trig_int = 1'b0;
		trig_int_d = 1'b0;
		quiet = 1'b0;
		rd_skip = 1'b0;
		rng_state = 32'hf4b5_0eb9;
		errors = 0;
		tests_run = 0;
		mscratch_m = '0;
		mtvec_m = TB_MTVEC;
		mie_m = '0;
		mstat_mie = 1'b0;
		mstat_mpie = 1'b0;
		repeat (4) @(posedge cpu_clk);
		reset <= 1'b0;

		quiet <= 1'b1;
		csr_cmd(CSR_READ, CSR_MSTATUS, '0, 32'h0, 1'b0);
		csr_cmd(CSR_READ, CSR_MIE, '0, 32'h0, 1'b0);
		csr_cmd(CSR_READ, CSR_MTVEC, '0, TB_MTVEC, 1'b0);
		csr_cmd(CSR_READ, CSR_MHARTID, '0, TB_HART, 1'b0);
		quiet <= 1'b0;
		test_done("reset values");

		// mscratch comes out of reset unknown
		rd_skip = 1'b1;
		csr_cmd(CSR_WRITE, CSR_MSCRATCH, 32'h0, 32'h0, 1'b0);
		rd_skip = 1'b0;
		csr_cmd(CSR_READ, CSR_MSCRATCH, '0, 32'h0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			r  = next_rand();
			op = csr_op_e'((r[1:0] % 3) + 1);
			nv = next_rand();
			if (i[0]) begin
				csr_cmd(op, CSR_MIE, nv, mie_m, 1'b0);
				case (op)
					CSR_SET:   mie_m = (mie_m | nv) & MIE_MASK;
					CSR_CLEAR: mie_m = mie_m & ~nv;
					default:   mie_m = nv & MIE_MASK;
				endcase
			end else begin
				csr_cmd(op, CSR_MSCRATCH, nv, mscratch_m, 1'b0);
				case (op)
					CSR_SET:   mscratch_m = mscratch_m | nv;
					CSR_CLEAR: mscratch_m = mscratch_m & ~nv;
					default:   mscratch_m = nv;
				endcase
			end
		end
		csr_cmd(CSR_READ, CSR_MSCRATCH, '0, mscratch_m, 1'b0);
		csr_cmd(CSR_READ, CSR_MIE, '0, mie_m, 1'b0);
		mtime <= {next_rand(), 32'h1234_5678};
		csr_cmd(CSR_READ, CSR_MTIME, '0, 32'h1234_5678, 1'b0);
		csr_cmd(CSR_READ, CSR_MTIMEH, '0, mtime[63:32], 1'b0);
		test_done("csr read write");

		exp_vec = mtvec_m & 32'hffff_fffc;
		rd_skip = 1'b1;	// unknown address has no value
		csr_cmd(CSR_READ, 12'h7c0, '0, 32'h0, 1'b1);
		rd_skip = 1'b0;
		exp_mepc = last_pc;
		r = last_instr;
		csr_cmd(CSR_READ, CSR_MCAUSE, '0, 32'd2, 1'b0);
		csr_cmd(CSR_READ, CSR_MTVAL, '0, r, 1'b0);
		csr_cmd(CSR_WRITE, CSR_MHARTID, 32'hdead_0001, TB_HART, 1'b1);
		exp_mepc = last_pc;
		r = last_instr;
		csr_cmd(CSR_READ, CSR_MTVAL, '0, r, 1'b0);
		csr_cmd(CSR_READ, CSR_MHARTID, '0, TB_HART, 1'b0);
		csr_cmd(CSR_READ, CSR_MEPC, '0, exp_mepc, 1'b0);
		test_done("illegal access");

		csr_cmd(CSR_SET, CSR_MSTATUS, 32'h8, 32'h0, 1'b0);
		mstat_mie = 1'b1;
		raise_exc(1'b0, 1'b1);
		csr_cmd(CSR_READ, CSR_MSTATUS, '0, 32'h80, 1'b0);
		csr_cmd(CSR_READ, CSR_MCAUSE, '0, 32'd11, 1'b0);
		csr_cmd(CSR_READ, CSR_MTVAL, '0, 32'h0, 1'b0);
		csr_cmd(CSR_READ, CSR_MEPC, '0, exp_mepc, 1'b0);
		raise_exc(1'b1, 1'b0);
		csr_cmd(CSR_READ, CSR_MCAUSE, '0, 32'd0, 1'b0);
		csr_cmd(CSR_READ, CSR_MTVAL, '0, exp_mepc | 32'h2, 1'b0);
		raise_exc(1'b1, 1'b1);	// misaligned wins
		csr_cmd(CSR_READ, CSR_MCAUSE, '0, 32'd0, 1'b0);
		csr_cmd(CSR_READ, CSR_MTVAL, '0, exp_mepc | 32'h2, 1'b0);
		csr_cmd(CSR_READ, CSR_MEPC, '0, exp_mepc, 1'b0);
		test_done("exceptions");

		vbase = (next_rand() & 32'h0000_ff00) | 32'h0001_0000;
		csr_cmd(CSR_WRITE, CSR_MTVEC, vbase | 32'h1, mtvec_m, 1'b0);
		mtvec_m = vbase | 32'h1;
		csr_cmd(CSR_WRITE, CSR_MIE, MIE_MASK, mie_m, 1'b0);
		mie_m = MIE_MASK;
		csr_cmd(CSR_SET, CSR_MSTATUS, 32'h8, {24'h0, mstat_mpie, 7'h0}, 1'b0);
		mstat_mie = 1'b1;
		exp_vec = vbase + 32'd44;
		exp_mepc = next_rand() & 32'hffff_fffc;
		@(posedge cpu_clk);
		pc        <= exp_mepc;
		ext_int   <= 1'b1;
		timer_int <= 1'b1;
		trig_int  <= 1'b1;
		@(posedge cpu_clk);
		trig_int  <= 1'b0;
		wait_trap();
		csr_cmd(CSR_READ, CSR_MCAUSE, '0, 32'h8000_000b, 1'b0);
		@(posedge cpu_clk);
		ext_int <= 1'b0;
		@(posedge cpu_clk);
		exp_vec  = vbase + 32'd28;
		mret     <= 1'b1;
		trig_int <= 1'b1;	// timer fires once MIE is back
		@(posedge cpu_clk);
		mret     <= 1'b0;
		trig_int <= 1'b0;
		wait_trap();
		exp_mepc = last_pc;	// pc still held from the mcause read
		csr_cmd(CSR_READ, CSR_MCAUSE, '0, 32'h8000_0007, 1'b0);
		csr_cmd(CSR_READ, CSR_MSTATUS, '0, 32'h80, 1'b0);
		@(posedge cpu_clk);
		timer_int <= 1'b0;
		csr_cmd(CSR_CLEAR, CSR_MSTATUS, 32'h8, 32'h80, 1'b0);
		@(posedge cpu_clk);
		ext_int   <= 1'b1;
		timer_int <= 1'b1;
		quiet     <= 1'b1;
		repeat (6) @(posedge cpu_clk);
		ext_int   <= 1'b0;
		timer_int <= 1'b0;
		repeat (3) @(posedge cpu_clk);
		quiet <= 1'b0;
		test_done("interrupts");

		@(posedge cpu_clk);
		mret <= 1'b1;
		@(posedge cpu_clk);
		mret <= 1'b0;
		csr_cmd(CSR_READ, CSR_MSTATUS, '0, 32'h88, 1'b0);
		csr_cmd(CSR_READ, CSR_MEPC, '0, exp_mepc, 1'b0);
		test_done("mret");

		repeat (2) @(posedge cpu_clk);
		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== machine_trap_unit.f ====
+incdir+verif
logic/trap_pkg.sv
logic/csr_decode.sv
logic/mcsr.sv
logic/trap_ctrl.sv
logic/machine_trap_unit.sv
verif/machine_trap_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the trap unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module machine_trap_unit_tb \
	-f machine_trap_unit.f -Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/Vmachine_trap_unit_tb > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TEST FAILED" sim.log \
	&& { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
